// ==== Bender.yml ====
package:
  name: wb_stage

sources:
  - files:
      - wb_pkg.sv
      - wb_trap_unit.sv
      - wb_commit.sv
      - wb_retire_counters.sv
      - wb_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_wb_stage.sv

// ==== tb_wb_ref.svh ====
// Write-back rule model, include inside a module that has already imported wb_pkg
`ifndef TB_WB_REF_SVH
`define TB_WB_REF_SVH

// --------------------
// Expected trap record, priority follows the cause list
function automatic exception_t expected_exception(input m2w_t m, input logic v);
   exception_t e;
   e = '0;
   if (v)
   begin
      e.flag = 1'b1;
      e.pc   = m.pc;
      e.tval = m.instruction;                    // Decode traps report the word itself
      if (m.ig_type == ILL_INSTR)
         e.cause = CAUSE_ILLEGAL;
      else if (m.ig_type == BR_INSTR && m.op_type == B_SRET && m.mode == U_MODE)
         e.cause = CAUSE_ILLEGAL;
      else if (m.ig_type == BR_INSTR && m.op_type == B_MRET && m.mode != M_MODE)
         e.cause = CAUSE_ILLEGAL;
      else if (m.ig_type == BR_INSTR && m.instr_err && m.op_type inside {B_ADD, B_JAL, B_JALR})
      begin
         e.cause = CAUSE_IADDR_MIS;
         e.tval  = m.br_pc;
      end
      else if (m.ig_type == SYS_INSTR && m.op_type == ECALL)
         e.cause = CAUSE_ECALL_BASE + {4'd0, m.mode};
      else if (m.ig_type == SYS_INSTR && m.op_type == EBREAK)
         e.cause = CAUSE_BREAK;
      else if (m.ig_type == CSR_INSTR && m.instr_err)
      begin
         e.cause = CAUSE_IACC_FLT;
         e.tval  = m.Rd_data;
      end
      else if (m.ig_type == LD_INSTR && (m.instr_err || m.mio_ack_fault))
      begin
         e.cause = m.instr_err ? CAUSE_LD_MIS : CAUSE_LD_FLT;
         e.tval  = m.ls_addr;
      end
      else if (m.ig_type == ST_INSTR && (m.instr_err || m.mio_ack_fault))
      begin
         e.cause = m.instr_err ? CAUSE_ST_MIS : CAUSE_ST_FLT;
         e.tval  = m.ls_addr;
      end
      else
         e = '0;                                 // Clean instruction
   end
   return e;
endfunction

// Trap vector first, then refetch after a store into I$ space
function automatic reload_t expected_reload(input m2w_t m, input logic v);
   reload_t r;
   r = '0;
   if (expected_exception(m, v).flag)
   begin
      r.pc_flag = 1'b1;
      r.addr    = m.trap_pc;
   end
   else if (v && m.ig_type == ST_INSTR && m.inv_flag)
   begin
      r.pc_flag = 1'b1;
      r.ic_flag = 1'b1;
      r.addr    = m.pc + (m.ci ? 32'd2 : 32'd4);
   end
   return r;
endfunction

// Rd commit before transfer gating
function automatic logic gpr_commits(input m2w_t m, input logic v);
   logic rd_ok;
   rd_ok = (m.ig_type inside {ALU_INSTR, IM_INSTR, IDR_INSTR, CSR_INSTR, LD_INSTR}) ||
           (m.ig_type == BR_INSTR && m.op_type inside {B_JAL, B_JALR});
   return v && rd_ok && m.Rd_wr && !expected_exception(m, v).flag;
endfunction

function automatic logic csr_commits(input m2w_t m, input logic v);
   return v && m.ig_type == CSR_INSTR && m.csr_wr && !expected_exception(m, v).flag;
endfunction

// Class counter hit by a transfer, -1 for a faulted store
function automatic int counter_index(input m2w_t m, input logic trapped);
   case (m.ig_type)
      ALU_INSTR: return int'(ALU_RET);
      BR_INSTR:  return (m.op_type == B_JAL)  ? int'(JAL_RET) :
                        (m.op_type == B_JALR) ? int'(JALR_RET) : int'(BXX_RET);
      IM_INSTR:  return int'(IM_RET);
      IDR_INSTR: return (m.op_type inside {REM, REMU}) ? int'(IR_RET) : int'(ID_RET);
      SYS_INSTR: return int'(SYS_RET);
      CSR_INSTR: return int'(CSR_RET);
      LD_INSTR:  return int'(LD_RET);
      ST_INSTR:  return trapped ? -1 : int'(ST_RET);
      default:   return int'(UNK_RET);
   endcase
endfunction

`endif

// ==== tb_wb_stage.sv ====
// Self-checking testbench for wb_stage at CNT_W 16, needs tb_wb_ref.svh on the include path
module tb_wb_stage;
   import wb_pkg::*;

   localparam int CNT_W     = 16;
   localparam int RESET_LEN = 10;                // Cycles with reset high
   localparam int N_RANDOM  = 400;
   localparam int DIR_LEN   = 2 + 19 + 8 + 5;    // Reset check, traps, commits, halt
   localparam int RAND_LEN  = N_RANDOM * 5;      // One idle and four tries per instruction
   localparam int TIMEOUT   = RESET_LEN + DIR_LEN + RAND_LEN + 200;

   logic       clk_in = 1'b0;
   logic       reset;
   logic       cpu_halt;
   logic       m2w_valid;
   m2w_t       m2w;
   logic       m2w_rdy;
   exception_t exception;
   reload_t    reload;
   gpr_wr_t    gpr_wr;
   csr_wr_t    csr_wr;
   fwd_gpr_t   fwd_gpr;
   fwd_csr_t   fwd_csr;
   logic [NUM_RET-1:0][CNT_W-1:0] ret_cnt;

   logic [CNT_W-1:0] cnt_model [NUM_RET];         // Expected counter bank
   mode_e      modes [3] = '{U_MODE, S_MODE, M_MODE};
   op_type_e   br_ops [3] = '{B_ADD, B_JAL, B_JALR};
   int         errors = 0;
   int         test_base = 0;                    // Error count at test start
   int         tests_run = 0;
   int         tests_failed = 0;
   int         cycles = 0;

   wb_stage #(
      .CNT_W (CNT_W)
   ) i_wb_stage
   (
      .clk_in    (clk_in),
      .reset     (reset),
      .cpu_halt  (cpu_halt),
      .m2w_valid (m2w_valid),
      .m2w       (m2w),
      .m2w_rdy   (m2w_rdy),
      .exception (exception),
      .reload    (reload),
      .gpr_wr    (gpr_wr),
      .csr_wr    (csr_wr),
      .fwd_gpr   (fwd_gpr),
      .fwd_csr   (fwd_csr),
      .ret_cnt   (ret_cnt)
   );

   `include "tb_wb_ref.svh"

   always
   begin
      #50;
      clk_in = 1'b1;
      #50;
      clk_in = 1'b0;
   end

   // --------------------
   // Helpers
   task automatic value_error(input string name, input logic [255:0] got,
                              input logic [255:0] exp);
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
   endtask

   task automatic begin_test();
      test_base = errors;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == test_base)
         $display("Test %s: passed", name);
      else
      begin
         tests_failed++;
         $display("Test %s: FAILED with %0d errors", name, errors - test_base);
      end
   endtask

   task automatic present(input m2w_t m);         // Drive and move to the sample point
      m2w       = m;
      m2w_valid = 1'b1;
      @(negedge clk_in);
   endtask

   task automatic advance();                      // Let the edge pass, then go idle
      @(posedge clk_in);
      #10;
      m2w_valid = 1'b0;
   endtask

   function automatic m2w_t build_instr(input ig_type_e ig, input op_type_e op, input mode_e md);
      m2w_t m;
      m              = '0;
      m.pc           = 32'h0000_2000;
      m.instruction  = 32'h00b5_0533;
      m.ig_type      = ig;
      m.op_type      = op;
      m.ls_addr      = 32'h8000_0106;
      m.br_pc        = 32'h0000_3002;
      m.mode         = md;
      m.trap_pc      = 32'h0000_0100;
      m.Rd_wr        = 1'b1;                      // Writes requested so suppression shows
      m.Rd_addr      = 5'd11;
      m.Rd_data      = 32'hcafe_0011;
      m.csr_wr       = 1'b1;
      m.csr_addr     = 12'h340;
      m.csr_wr_data  = 32'h1234_5678;
      m.csr_fwd_data = 32'h8765_4321;
      return m;
   endfunction

   function automatic m2w_t random_instr();
      m2w_t m;
      m               = '0;
      m.pc            = $urandom & 32'hffff_fffc;
      m.instruction   = $urandom;
      m.ig_type       = ig_type_e'($urandom % 9);
      m.op_type       = op_type_e'($urandom % 12);
      m.ls_addr       = $urandom;
      m.br_pc         = $urandom;
      m.inv_flag      = 1'($urandom);
      m.ci            = ($urandom % 4) == 0;
      m.instr_err     = ($urandom % 4) == 0;
      m.mio_ack_fault = ($urandom % 4) == 0;
      m.mode          = modes[$urandom % 3];
      m.trap_pc       = $urandom & 32'hffff_fffc;
      m.Rd_wr         = ($urandom % 8) != 0;
      m.Rd_addr       = 5'($urandom);
      m.Rd_data       = $urandom;
      m.csr_wr        = 1'($urandom);
      m.csr_addr      = 12'($urandom);
      m.csr_wr_data   = $urandom;
      m.csr_fwd_data  = $urandom;
      return m;
   endfunction

   task automatic check_trap(input m2w_t m, input logic flag, input logic [5:0] cause);
      present(m);
      if (exception.flag !== flag)
         value_error("exception.flag", exception.flag, flag);
      if (flag && exception.cause !== cause)
         value_error("exception.cause", exception.cause, cause);
      if (flag && reload.addr !== m.trap_pc)
         value_error("reload.addr", reload.addr, m.trap_pc);
      if (flag && (gpr_wr.wr !== 1'b0 || csr_wr.wr !== 1'b0))
      begin
         errors++;
         $display("A trapped instruction wrote a register at %0t", $time);
      end
      advance();
   endtask

   task automatic check_commit(input m2w_t m, input logic with_csr);
      present(m);
      if (gpr_wr.wr !== 1'b1 || gpr_wr.addr !== m.Rd_addr || gpr_wr.data !== m.Rd_data)
         value_error("gpr_wr", gpr_wr, {1'b1, m.Rd_addr, m.Rd_data});
      if (with_csr && (csr_wr.wr !== 1'b1 || csr_wr.addr !== m.csr_addr ||
                       csr_wr.data !== m.csr_wr_data))
         value_error("csr_wr", csr_wr, {1'b1, m.csr_addr, m.csr_wr_data});
      advance();
   endtask

   task automatic check_store(input m2w_t m, input logic [31:0] exp_addr);
      present(m);
      if (reload !== {1'b1, 1'b1, exp_addr})
         value_error("reload", reload, {1'b1, 1'b1, exp_addr});
      advance();
   endtask

   // --------------------
   // Output compare, once per cycle while inputs are stable
   always @(negedge clk_in)
   begin : compare_outputs
      exception_t exp_exc;
      logic       exp_rdy;
      logic       exp_xfer;
      logic       exp_gpr;
      logic       exp_csr;
      int         idx;
      exp_exc  = expected_exception(m2w, m2w_valid);
      exp_rdy  = !reset && !cpu_halt;
      exp_xfer = exp_rdy && m2w_valid;
      exp_gpr  = gpr_commits(m2w, m2w_valid);
      exp_csr  = csr_commits(m2w, m2w_valid);
      if (m2w_rdy !== exp_rdy)
         value_error("m2w_rdy", m2w_rdy, exp_rdy);
      if (exception !== exp_exc)
         value_error("exception", exception, exp_exc);
      if (reload !== expected_reload(m2w, m2w_valid))
         value_error("reload", reload, expected_reload(m2w, m2w_valid));
      if (gpr_wr.wr !== (exp_xfer && exp_gpr))
         value_error("gpr_wr.wr", gpr_wr.wr, exp_xfer && exp_gpr);
      if (exp_gpr && (gpr_wr.addr !== m2w.Rd_addr || gpr_wr.data !== m2w.Rd_data))
         value_error("gpr_wr.data", gpr_wr.data, m2w.Rd_data);
      if (csr_wr.wr !== (exp_xfer && exp_csr))
         value_error("csr_wr.wr", csr_wr.wr, exp_xfer && exp_csr);
      if (exp_csr && (csr_wr.addr !== m2w.csr_addr || csr_wr.data !== m2w.csr_wr_data))
         value_error("csr_wr.data", csr_wr.data, m2w.csr_wr_data);
      if (fwd_gpr.valid !== m2w_valid || fwd_gpr.gpr.wr !== exp_gpr)
         value_error("fwd_gpr.wr", fwd_gpr.gpr.wr, exp_gpr);
      if (exp_gpr && (fwd_gpr.gpr.addr !== m2w.Rd_addr || fwd_gpr.gpr.data !== m2w.Rd_data))
         value_error("fwd_gpr.gpr", fwd_gpr.gpr, {1'b1, m2w.Rd_addr, m2w.Rd_data});
      if (fwd_csr.valid !== m2w_valid || fwd_csr.wr !== exp_csr)
         value_error("fwd_csr.wr", fwd_csr.wr, exp_csr);
      if (exp_csr && (fwd_csr.addr !== m2w.csr_addr || fwd_csr.data !== m2w.csr_fwd_data))
         value_error("fwd_csr", fwd_csr, {1'b1, 1'b1, m2w.csr_addr, m2w.csr_fwd_data});
      for (int i = 0; i < NUM_RET; i++)
         if (ret_cnt[i] !== cnt_model[i])
            value_error($sformatf("ret_cnt[%0d]", i), ret_cnt[i], cnt_model[i]);

      // Model moves with the coming edge
      if (reset)
      begin
         for (int i = 0; i < NUM_RET; i++)
            cnt_model[i] = '0;
      end
      else if (exp_xfer)
      begin
         idx = counter_index(m2w, exp_exc.flag);
         if (idx >= 0)
            cnt_model[idx] = cnt_model[idx] + 1'b1;
         if (exp_exc.flag)
            cnt_model[EXC_RET] = cnt_model[EXC_RET] + 1'b1;
      end
   end

   always @(posedge clk_in)
   begin
      cycles++;
      if (cycles >= TIMEOUT)
      begin
         $display("Timeout, run exceeded %0d cycles", TIMEOUT);
         $display("Test failures found");
         $finish;
      end
   end

   // --------------------
   // Stimulus
   initial
   begin
      m2w_t m;
      int   stall;
      logic taken;
      logic [NUM_RET-1:0][CNT_W-1:0] snap;
      void'($urandom(32'hb981_ecad));
      reset     = 1'b1;
      cpu_halt  = 1'b0;
      m2w_valid = 1'b0;
      m2w       = '0;
      for (int i = 0; i < NUM_RET; i++)
         cnt_model[i] = '0;
      repeat (RESET_LEN) @(posedge clk_in);
      #10;
      reset = 1'b0;

      begin_test();
      @(negedge clk_in);
      if (m2w_rdy !== 1'b1)
         value_error("m2w_rdy", m2w_rdy, 1'b1);
      if (ret_cnt !== '0)
         value_error("ret_cnt", ret_cnt, '0);
      if (exception.flag !== 1'b0 || reload !== '0 || gpr_wr.wr !== 1'b0 || csr_wr.wr !== 1'b0)
      begin
         errors++;
         $display("A strobe is active with valid low after reset");
      end
      @(posedge clk_in);
      #10;
      end_test("reset");

      begin_test();
      check_trap(build_instr(ILL_INSTR, OTHER, M_MODE), 1'b1, CAUSE_ILLEGAL);
      for (int i = 0; i < 3; i++)
      begin
         check_trap(build_instr(BR_INSTR, B_SRET, modes[i]), i == 0, CAUSE_ILLEGAL); // U only
         check_trap(build_instr(BR_INSTR, B_MRET, modes[i]), i < 2, CAUSE_ILLEGAL);  // U and S
         check_trap(build_instr(SYS_INSTR, ECALL, modes[i]), 1'b1, (i == 2) ? 6'd11 : 6'(8 + i));
         m = build_instr(BR_INSTR, br_ops[i], M_MODE);
         m.instr_err = 1'b1;                       // Target not word aligned
         check_trap(m, 1'b1, CAUSE_IADDR_MIS);
      end
      check_trap(build_instr(SYS_INSTR, EBREAK, S_MODE), 1'b1, CAUSE_BREAK);
      m = build_instr(CSR_INSTR, OTHER, U_MODE);
      m.instr_err = 1'b1;
      check_trap(m, 1'b1, CAUSE_IACC_FLT);
      m = build_instr(LD_INSTR, OTHER, M_MODE);
      m.instr_err = 1'b1;
      check_trap(m, 1'b1, CAUSE_LD_MIS);
      m.instr_err     = 1'b0;
      m.mio_ack_fault = 1'b1;
      check_trap(m, 1'b1, CAUSE_LD_FLT);
      m.ig_type = ST_INSTR;
      check_trap(m, 1'b1, CAUSE_ST_FLT);
      m.instr_err = 1'b1;                          // Misalign wins over the bus fault
      check_trap(m, 1'b1, CAUSE_ST_MIS);
      end_test("directed traps");

      begin_test();
      check_commit(build_instr(ALU_INSTR, OTHER, M_MODE), 1'b0);
      check_commit(build_instr(IM_INSTR, OTHER, S_MODE), 1'b0);
      check_commit(build_instr(IDR_INSTR, DIV, U_MODE), 1'b0);
      check_commit(build_instr(BR_INSTR, B_JAL, M_MODE), 1'b0);
      check_commit(build_instr(CSR_INSTR, OTHER, M_MODE), 1'b1);
      check_commit(build_instr(LD_INSTR, OTHER, M_MODE), 1'b0);
      m = build_instr(ST_INSTR, OTHER, M_MODE);
      m.inv_flag = 1'b1;
      check_store(m, m.pc + 32'd4);
      m.ci = 1'b1;
      check_store(m, m.pc + 32'd2);
      end_test("clean commits");

      begin_test();
      snap      = ret_cnt;
      cpu_halt  = 1'b1;
      m2w       = build_instr(ALU_INSTR, OTHER, M_MODE);
      m2w_valid = 1'b1;
      repeat (3)
      begin
         @(negedge clk_in);
         if (m2w_rdy !== 1'b0 || gpr_wr.wr !== 1'b0 || csr_wr.wr !== 1'b0)
            value_error("m2w_rdy", m2w_rdy, 1'b0);
         if (fwd_gpr.valid !== 1'b1 || fwd_gpr.gpr.addr !== m2w.Rd_addr ||
             fwd_gpr.gpr.data !== m2w.Rd_data)
            value_error("fwd_gpr", fwd_gpr, {1'b1, 1'b1, m2w.Rd_addr, m2w.Rd_data});
      end
      if (ret_cnt !== snap)
      begin
         errors++;
         $display("Counters changed while cpu_halt was high");
      end
      @(posedge clk_in);
      #10;
      cpu_halt = 1'b0;
      @(negedge clk_in);                           // Transfer at the next edge
      advance();
      end_test("halt");

      begin_test();
      for (int n = 0; n < N_RANDOM; n++)
      begin
         if ($urandom % 4 == 0)
         begin
            m2w_valid = 1'b0;                      // Idle gap, payload is noise
            m2w       = random_instr();
            cpu_halt  = 1'($urandom);
            @(posedge clk_in);
            #10;
         end
         m2w       = random_instr();
         m2w_valid = 1'b1;
         stall     = 0;
         taken     = 1'b0;
         while (!taken)
         begin
            cpu_halt = (stall < 3) && ($urandom % 4 == 0); // Halt ends after three stalls
            @(negedge clk_in);
            taken = m2w_rdy;
            @(posedge clk_in);
            #10;
            stall++;
         end
         cpu_halt  = 1'b0;
         m2w_valid = 1'b0;
      end
      @(negedge clk_in);                           // Last counter update gets compared
      #10;
      end_test("random stream");

      $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+.
wb_pkg.sv
wb_trap_unit.sv
wb_commit.sv
wb_retire_counters.sv
wb_stage.sv
tb_wb_stage.sv

// ==== wb_commit.sv ====
// GPR and CSR write gating, writes fire only on a transfer while forwards follow valid
module wb_commit
(
   input  logic               clk_in,
   input  logic               xfer,               // Instruction retires this cycle
   input  wb_pkg::m2w_t       m2w,
   input  logic               m2w_valid,
   input  wb_pkg::exception_t trap_exc,           // From trap unit
   output wb_pkg::gpr_wr_t    gpr_wr,
   output wb_pkg::csr_wr_t    csr_wr,
   output wb_pkg::fwd_gpr_t   fwd_gpr,
   output wb_pkg::fwd_csr_t   fwd_csr
);
   import wb_pkg::*;

   logic    rd_class;                             // Class that produces Rd
   gpr_wr_t gpr_rec;                              // Ungated GPR result
   csr_wr_t csr_rec;
   logic    keep;                                 // Valid and not trapped

   // Classes allowed to write Rd
   always_comb
   begin
      case (m2w.ig_type)
         ALU_INSTR, IM_INSTR, IDR_INSTR, CSR_INSTR, LD_INSTR:
            rd_class = 1'b1;
         BR_INSTR:
            rd_class = (m2w.op_type inside {B_JAL, B_JALR}); // Link register only
         default:
            rd_class = 1'b0;
      endcase
   end

   assign keep = m2w_valid & !trap_exc.flag;

   // --------------------
   // Results of this instruction
   assign gpr_rec.wr   = keep & rd_class & m2w.Rd_wr;
   assign gpr_rec.addr = (keep & rd_class) ? m2w.Rd_addr : '0;
   assign gpr_rec.data = (keep & rd_class) ? m2w.Rd_data : '0;

   assign csr_rec.wr   = keep & (m2w.ig_type == CSR_INSTR) & m2w.csr_wr;
   assign csr_rec.addr = csr_rec.wr ? m2w.csr_addr : '0;
   assign csr_rec.data = csr_rec.wr ? m2w.csr_wr_data : '0;

   // Register file ports
   assign gpr_wr.wr    = xfer & gpr_rec.wr;
   assign gpr_wr.addr  = gpr_rec.addr;
   assign gpr_wr.data  = gpr_rec.data;
   assign csr_wr.wr    = xfer & csr_rec.wr;
   assign csr_wr.addr  = csr_rec.addr;
   assign csr_wr.data  = csr_rec.data;

   // Forwards stay up during a halt
   assign fwd_gpr.valid = m2w_valid;
   assign fwd_gpr.gpr   = gpr_rec;
   assign fwd_csr.valid = m2w_valid;
   assign fwd_csr.wr    = csr_rec.wr;
   assign fwd_csr.addr  = csr_rec.addr;
   assign fwd_csr.data  = csr_rec.wr ? m2w.csr_fwd_data : '0;

   // A transfer strobe only ever comes with an instruction behind it
   a_xfer_valid: assert property (@(posedge clk_in) xfer |-> m2w_valid);

endmodule

// ==== wb_pkg.sv ====
// RV32IM write-back definitions for a 32 bit core without C, F or interrupt support
package wb_pkg;

   // --------------------
   // Widths
   localparam int XLEN    = 32;                   // Register and PC width
   localparam int GPR_AW  = 5;                    // 32 GPRs
   localparam int CSR_AW  = 12;                   // Full CSR address space
   localparam int NUM_RET = 13;                   // Number of retirement counters

   // --------------------
   // Instruction class as decoded upstream
   typedef enum logic [3:0] {
      ILL_INSTR,                                  // Illegal encoding
      ALU_INSTR,
      BR_INSTR,                                   // Branches, jumps and xRET
      IM_INSTR,                                   // Multiply
      IDR_INSTR,                                  // Divide and remainder
      SYS_INSTR,
      CSR_INSTR,
      LD_INSTR,
      ST_INSTR
   } ig_type_e;

   // Operation within a class
   typedef enum logic [3:0] {
      B_ADD,                                      // Conditional branch
      B_JAL,
      B_JALR,
      B_SRET,
      B_MRET,
      ECALL,
      EBREAK,
      WFI,
      REM,
      REMU,
      DIV,
      OTHER
   } op_type_e;

   // Privilege mode, encoding 2 is reserved
   typedef enum logic [1:0] {
      U_MODE = 2'd0,
      S_MODE = 2'd1,
      M_MODE = 2'd3
   } mode_e;

   // --------------------
   // Synchronous exception causes
   localparam logic [5:0] CAUSE_IADDR_MIS  = 6'd0;
   localparam logic [5:0] CAUSE_IACC_FLT   = 6'd1;
   localparam logic [5:0] CAUSE_ILLEGAL    = 6'd2;
   localparam logic [5:0] CAUSE_BREAK      = 6'd3;
   localparam logic [5:0] CAUSE_LD_MIS     = 6'd4;
   localparam logic [5:0] CAUSE_LD_FLT     = 6'd5;
   localparam logic [5:0] CAUSE_ST_MIS     = 6'd6;
   localparam logic [5:0] CAUSE_ST_FLT     = 6'd7;
   localparam logic [5:0] CAUSE_ECALL_BASE = 6'd8;  // Mode is added on top

   // Retirement counter index
   typedef enum logic [3:0] {
      ALU_RET, BXX_RET, JAL_RET, JALR_RET, IM_RET, ID_RET, IR_RET,
      SYS_RET, CSR_RET, LD_RET, ST_RET, UNK_RET, EXC_RET
   } ret_class_e;

   // --------------------
   // Memory stage to write-back record
   typedef struct packed {
      logic [XLEN-1:0]   pc;
      logic [XLEN-1:0]   instruction;
      ig_type_e          ig_type;
      op_type_e          op_type;
      logic [XLEN-1:0]   ls_addr;                 // Load/store effective address
      logic [XLEN-1:0]   br_pc;                   // Branch or jump target
      logic              inv_flag;                // Store also hit I$ space
      logic              ci;                      // 16 bit instruction
      logic              instr_err;               // Misaligned or bad CSR access
      logic              mio_ack_fault;           // Bus reported an access fault
      mode_e             mode;                    // Mode the instruction ran in
      logic [XLEN-1:0]   trap_pc;                 // Trap vector for this instruction
      logic              Rd_wr;
      logic [GPR_AW-1:0] Rd_addr;
      logic [XLEN-1:0]   Rd_data;
      logic              csr_wr;
      logic [CSR_AW-1:0] csr_addr;
      logic [XLEN-1:0]   csr_wr_data;
      logic [XLEN-1:0]   csr_fwd_data;            // Value seen by younger readers
   } m2w_t;

   typedef struct packed {
      logic              flag;
      logic [5:0]        cause;
      logic [XLEN-1:0]   pc;                      // Faulting instruction address
      logic [XLEN-1:0]   tval;
   } exception_t;

   typedef struct packed {
      logic              pc_flag;                 // Fetch must restart
      logic              ic_flag;                 // Restart caused by I$ invalidate
      logic [XLEN-1:0]   addr;
   } reload_t;

   typedef struct packed {
      logic              wr;
      logic [GPR_AW-1:0] addr;
      logic [XLEN-1:0]   data;
   } gpr_wr_t;

   typedef struct packed {
      logic              wr;
      logic [CSR_AW-1:0] addr;
      logic [XLEN-1:0]   data;
   } csr_wr_t;

   typedef struct packed {
      logic              valid;
      gpr_wr_t           gpr;
   } fwd_gpr_t;

   typedef struct packed {
      logic              valid;
      logic              wr;
      logic [CSR_AW-1:0] addr;
      logic [XLEN-1:0]   data;
   } fwd_csr_t;

endpackage

// ==== wb_retire_counters.sv ====
// Registered retirement counters per class, counts wrap at CNT_W bits and are visible a cycle later
module wb_retire_counters
#(
   parameter int CNT_W = 16                       // Counter width
)
(
   input  logic               clk_in,
   input  logic               reset,              // Synchronous, active high
   input  logic               xfer,
   input  wb_pkg::m2w_t       m2w,
   input  wb_pkg::exception_t trap_exc,
   output logic [wb_pkg::NUM_RET-1:0][CNT_W-1:0] ret_cnt
);
   import wb_pkg::*;

   ret_class_e         cls;                       // Class counter for this instruction
   logic               cls_bump;                  // Class counter takes part
   logic [NUM_RET-1:0] inc;                       // One hot plus EXC bit

   // --------------------
   // Class select
   always_comb
   begin
      cls_bump = 1'b1;
      case (m2w.ig_type)
         ALU_INSTR: cls = ALU_RET;
         BR_INSTR:
         begin
            case (m2w.op_type)
               B_JAL:   cls = JAL_RET;
               B_JALR:  cls = JALR_RET;
               default: cls = BXX_RET;            // Bxx, SRET and MRET
            endcase
         end
         IM_INSTR:  cls = IM_RET;
         IDR_INSTR: cls = (m2w.op_type inside {REM, REMU}) ? IR_RET : ID_RET;
         SYS_INSTR: cls = SYS_RET;
         CSR_INSTR: cls = CSR_RET;
         LD_INSTR:  cls = LD_RET;
         ST_INSTR:
         begin
            cls      = ST_RET;
            cls_bump = !trap_exc.flag;            // Faulted store counts as EXC only
         end
         default:   cls = UNK_RET;                // ILL and unused codes
      endcase
   end

   always_comb
   begin
      inc          = '0;
      inc[cls]     = cls_bump;
      inc[EXC_RET] = trap_exc.flag;
   end

   // --------------------
   // Counter bank
   always_ff @(posedge clk_in)
   begin
      if (reset)
         ret_cnt <= '0;
      else if (xfer)
      begin
         for (int i = 0; i < NUM_RET; i++)
            if (inc[i])
               ret_cnt[i] <= ret_cnt[i] + 1'b1;  // Wraps
      end
   end

   // Counters move only at the end of a transfer cycle
   a_hold: assert property (@(posedge clk_in) disable iff (reset)
      !xfer |=> $stable(ret_cnt));

   // Each trapped transfer shows up once in the EXC count on the next cycle
   a_exc_count: assert property (@(posedge clk_in) disable iff (reset)
      (xfer && trap_exc.flag) |=>
         ret_cnt[EXC_RET] == CNT_W'($past(ret_cnt[EXC_RET]) + 1'b1));

endmodule

// ==== wb_stage.sv ====
// Write-back stage top, takes one instruction per cycle and is never busy except in reset or halt
module wb_stage
#(
   parameter int CNT_W = 16                       // Retirement counter width
)
(
   input  logic               clk_in,
   input  logic               reset,              // Synchronous, active high

   input  logic               cpu_halt,           // Stop accepting from memory stage

   // --------------------
   // Memory stage input
   input  logic               m2w_valid,
   input  wb_pkg::m2w_t       m2w,
   output logic               m2w_rdy,

   // Trap and fetch restart
   output wb_pkg::exception_t exception,
   output wb_pkg::reload_t    reload,

   // Register file writes and forwards
   output wb_pkg::gpr_wr_t    gpr_wr,
   output wb_pkg::csr_wr_t    csr_wr,
   output wb_pkg::fwd_gpr_t   fwd_gpr,
   output wb_pkg::fwd_csr_t   fwd_csr,

   // Retirement counts indexed by class
   output logic [wb_pkg::NUM_RET-1:0][CNT_W-1:0] ret_cnt
);
   import wb_pkg::*;

   logic       xfer;                              // Handshake completes this cycle
   exception_t trap_exc;                          // Shared trap record

   // --------------------
   // Handshake
   assign m2w_rdy   = !reset & !cpu_halt;
   assign xfer      = m2w_valid & m2w_rdy;
   assign exception = trap_exc;

   wb_trap_unit i_wb_trap_unit
   (
      .m2w       (m2w),
      .m2w_valid (m2w_valid),
      .exception (trap_exc),
      .reload    (reload)
   );

   wb_commit i_wb_commit
   (
      .clk_in    (clk_in),
      .xfer      (xfer),
      .m2w       (m2w),
      .m2w_valid (m2w_valid),
      .trap_exc  (trap_exc),
      .gpr_wr    (gpr_wr),
      .csr_wr    (csr_wr),
      .fwd_gpr   (fwd_gpr),
      .fwd_csr   (fwd_csr)
   );

   wb_retire_counters #(
      .CNT_W (CNT_W)
   ) i_wb_retire_counters
   (
      .clk_in    (clk_in),
      .reset     (reset),
      .xfer      (xfer),
      .m2w       (m2w),
      .trap_exc  (trap_exc),
      .ret_cnt   (ret_cnt)
   );

endmodule

// ==== wb_trap_unit.sv ====
// Combinational trap detect for one instruction, C extension absent so misaligned targets trap
module wb_trap_unit
(
   input  wb_pkg::m2w_t       m2w,                // Instruction from memory stage
   input  logic               m2w_valid,
   output wb_pkg::exception_t exception,          // Trap record, zero when idle
   output wb_pkg::reload_t    reload              // Fetch restart request
);
   import wb_pkg::*;

   logic            trap;                         // Instruction raises an exception
   logic [5:0]      cause;
   logic [XLEN-1:0] tval;
   logic            st_reload;                    // Clean store into I$ space

   // --------------------
   // Cause select, one per class
   always_comb
   begin
      trap      = 1'b0;
      cause     = '0;
      tval      = '0;
      st_reload = 1'b0;

      if (m2w_valid)
      begin
         case (m2w.ig_type)
            ILL_INSTR:
            begin
               trap  = 1'b1;
               cause = CAUSE_ILLEGAL;
               tval  = m2w.instruction;
            end

            BR_INSTR:
            begin
               case (m2w.op_type)
                  B_SRET:
                  begin
                     if (m2w.mode < S_MODE)       // Only U mode is below S
                     begin
                        trap  = 1'b1;
                        cause = CAUSE_ILLEGAL;
                        tval  = m2w.instruction;
                     end
                  end
                  B_MRET:
                  begin
                     if (m2w.mode < M_MODE)       // S, U and reserved mode
                     begin
                        trap  = 1'b1;
                        cause = CAUSE_ILLEGAL;
                        tval  = m2w.instruction;
                     end
                  end
                  B_ADD, B_JAL, B_JALR:
                  begin
                     if (m2w.instr_err)           // Target not word aligned
                     begin
                        trap  = 1'b1;
                        cause = CAUSE_IADDR_MIS;
                        tval  = m2w.br_pc;
                     end
                  end
                  default:
                  begin
                     trap = 1'b0;
                  end
               endcase
            end

            SYS_INSTR:
            begin
               if (m2w.op_type == ECALL)
               begin
                  trap  = 1'b1;
                  cause = CAUSE_ECALL_BASE + 6'(m2w.mode); // 8, 9 or 11
                  tval  = m2w.instruction;
               end
               else if (m2w.op_type == EBREAK)
               begin
                  trap  = 1'b1;
                  cause = CAUSE_BREAK;
                  tval  = m2w.instruction;
               end
            end

            CSR_INSTR:
            begin
               if (m2w.instr_err)
               begin
                  trap  = 1'b1;
                  cause = CAUSE_IACC_FLT;
                  tval  = m2w.Rd_data;             // Execute parks the bad address here
               end
            end

            LD_INSTR:
            begin
               trap  = m2w.instr_err | m2w.mio_ack_fault;
               cause = m2w.instr_err ? CAUSE_LD_MIS : CAUSE_LD_FLT; // Misalign wins
               tval  = m2w.ls_addr;
            end

            ST_INSTR:
            begin
               trap      = m2w.instr_err | m2w.mio_ack_fault;
               cause     = m2w.instr_err ? CAUSE_ST_MIS : CAUSE_ST_FLT;
               tval      = m2w.ls_addr;
               st_reload = !trap & m2w.inv_flag;
            end

            default:
            begin
               trap = 1'b0;                        // ALU, IM, IDR never trap here
            end
         endcase
      end
   end

   // --------------------
   // Trap record and fetch restart
   always_comb
   begin
      exception = '0;
      reload    = '0;
      if (trap)
      begin
         exception.flag  = 1'b1;
         exception.cause = cause;
         exception.pc    = m2w.pc;
         exception.tval  = tval;
         reload.pc_flag  = 1'b1;
         reload.addr     = m2w.trap_pc;            // Vector from CSR unit
      end
      else if (st_reload)
      begin
         // Refetch the instruction after the store so stale I$ lines are dropped
         reload.pc_flag  = 1'b1;
         reload.ic_flag  = 1'b1;
         reload.addr     = m2w.pc + (m2w.ci ? XLEN'(2) : XLEN'(4));
      end
   end

endmodule
